// ==== hdl/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN 32
`define REG_COUNT 32

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/isaPkg.sv ====
`default_nettype none

package isaPkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	localparam logic [2:0] F3_BEQ = 3'b000, F3_JALR = 3'b000;
	localparam logic [2:0] F3_LB = 3'b000, F3_LH = 3'b001, F3_LW = 3'b010; // also sb sh sw
	localparam logic [2:0] F3_LBU = 3'b100, F3_LHU = 3'b101;
	localparam logic [2:0] F3_ADD = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011, F3_XOR = 3'b100, F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110, F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000; // sub, sra

	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== hdl/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} aluOp_t;

	// register write source
	typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC4 = 2'd2, WB_PCIMM = 2'd3} wbSel_t;

	typedef enum logic [1:0] {PC_PLUS4 = 2'd0, PC_BRANCH = 2'd1, PC_JALR = 2'd2} pcSel_t;

	// encodings match funct3[1:0] of loads and stores
	typedef enum logic [1:0] {BYTE = 2'd0, HALF = 2'd1, WORD = 2'd2} memSize_t;

	typedef enum logic [1:0] {JMP_NONE = 2'd0, JMP_JAL = 2'd1, JMP_JALR = 2'd2} jump_t;

endpackage

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module fetchUnit import ctrlPkg::*; (
	input wire clk,
	input wire arstN,
	input wire [`XLEN-1:0] imm,
	input wire [`XLEN-1:0] aluResult,
	input wire zero,
	input wire branch,
	input wire jump_t jump,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] pcPlus4,
	output logic [`XLEN-1:0] pcImm
);
	pcSel_t pcSel;
	logic [`XLEN-1:0] pcNext;

	assign pcPlus4 = pc + `XLEN'd4;
	assign pcImm = pc + imm; // branch and jal target, also auipc

	always_comb begin
		if (jump == JMP_JALR)
			pcSel = PC_JALR;
		else if (jump == JMP_JAL || (branch && zero))
			pcSel = PC_BRANCH; // beq taken
		else
			pcSel = PC_PLUS4;
	end

	always_comb begin
		case (pcSel)
			PC_BRANCH: pcNext = pcImm;
			PC_JALR: pcNext = {aluResult[`XLEN-1:1], 1'b0};
			default: pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= `RESET_PC;
		else
			pc <= pcNext;
	end

	// b and j immediates are even, jalr clears bit 0
	pcAligned: assert property (@(posedge clk) disable iff (!arstN) !pc[0]);

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module decoder import isaPkg::*, ctrlPkg::*; (
	input wire [31:0] inst,
	output logic [`XLEN-1:0] imm,
	output aluOp_t aluOp,
	output logic aluSrc,
	output logic regWrite,
	output logic memWrite,
	output wbSel_t wbSel,
	output memSize_t memSize,
	output logic loadSigned,
	output logic branch,
	output jump_t jump,
	output logic useZeroRs1,
	output logic invalid
);
	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] immI, immS, immB, immU, immJ;
	logic valid;

	function automatic aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD: return alt ? ALU_SUB : ALU_ADD;
			F3_SLL: return ALU_SLL;
			F3_SLT: return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR: return ALU_XOR;
			F3_SR: return alt ? ALU_SRA : ALU_SRL;
			F3_OR: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{(`XLEN-12){inst[31]}}, inst[31:20]};
	assign immS = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		imm = immI;
		aluOp = ALU_ADD;
		aluSrc = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		wbSel = WB_ALU;
		memSize = WORD;
		loadSigned = 1'b0;
		branch = 1'b0;
		jump = JMP_NONE;
		useZeroRs1 = 1'b0;
		valid = 1'b0;
		case (opcode)
			OPC_LUI: begin
				valid = 1'b1;
				imm = immU;
				aluSrc = 1'b1;
				useZeroRs1 = 1'b1; // 0 + imm through the alu
				regWrite = 1'b1;
			end
			OPC_AUIPC: begin
				valid = 1'b1;
				imm = immU;
				wbSel = WB_PCIMM;
				regWrite = 1'b1;
			end
			OPC_JAL: begin
				valid = 1'b1;
				imm = immJ;
				jump = JMP_JAL;
				wbSel = WB_PC4;
				regWrite = 1'b1;
			end
			OPC_JALR: begin
				valid = (funct3 == F3_JALR);
				aluSrc = 1'b1;
				jump = JMP_JALR;
				wbSel = WB_PC4;
				regWrite = 1'b1;
			end
			OPC_BRANCH: begin
				valid = (funct3 == F3_BEQ); // beq only
				imm = immB;
				aluOp = ALU_SUB;
				branch = 1'b1;
			end
			OPC_LOAD: begin
				valid = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
				aluSrc = 1'b1;
				wbSel = WB_MEM;
				regWrite = 1'b1;
				memSize = memSize_t'(funct3[1:0]);
				loadSigned = !funct3[2];
			end
			OPC_STORE: begin
				valid = funct3 inside {F3_LB, F3_LH, F3_LW};
				imm = immS;
				aluSrc = 1'b1;
				memWrite = 1'b1;
				memSize = memSize_t'(funct3[1:0]);
			end
			OPC_OPIMM: begin
				valid = (funct3 != F3_SLL) && (funct3 != F3_SR); // no immediate shifts
				aluSrc = 1'b1;
				aluOp = aluFromFunct3(funct3, 1'b0);
				regWrite = 1'b1;
			end
			OPC_OP: begin
				valid = (funct7 == F7_BASE)
					|| (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
				aluOp = aluFromFunct3(funct3, funct7[5]);
				regWrite = 1'b1;
			end
			OPC_SYSTEM: valid = (inst == INST_EBREAK);
			default: valid = 1'b0;
		endcase
		// an unsupported word must behave as a plain pc + 4
		if (!valid) begin
			regWrite = 1'b0;
			memWrite = 1'b0;
			branch = 1'b0;
			jump = JMP_NONE;
			memSize = WORD;
		end
	end

	assign invalid = !valid;

	always_comb begin
		invalidQuiet: assert (!invalid || (!regWrite && !memWrite));
	end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module regFile (
	input wire clk,
	input wire arstN,
	input wire [$clog2(`REG_COUNT)-1:0] rs1Addr,
	input wire [$clog2(`REG_COUNT)-1:0] rs2Addr,
	input wire [$clog2(`REG_COUNT)-1:0] rdAddr,
	input wire [`XLEN-1:0] writeData,
	input wire regWrite,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data
);
	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (regWrite && rdAddr != '0) begin // x0 stays zero
			regs[rdAddr] <= writeData;
		end
	end

	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	// entry 0 is only ever cleared, never written
	x0Zero: assert property (@(posedge clk) disable iff (!arstN)
		(rs1Addr != '0 || rs1Data == '0) && (rs2Addr != '0 || rs2Data == '0));

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module alu import ctrlPkg::*; (
	input wire [`XLEN-1:0] rs1Data,
	input wire [`XLEN-1:0] rs2Data,
	input wire [`XLEN-1:0] imm,
	input wire aluSrc,
	input wire aluOp_t aluOp,
	output logic [`XLEN-1:0] result,
	output logic zero
);
	logic [`XLEN-1:0] opB;
	logic [$clog2(`XLEN)-1:0] shamt;
	logic lessSigned, lessUnsigned;

	assign opB = aluSrc ? imm : rs2Data;
	assign shamt = opB[$clog2(`XLEN)-1:0]; // low 5 bits only
	assign lessSigned = $signed(rs1Data) < $signed(opB);
	assign lessUnsigned = rs1Data < opB;

	always_comb begin
		case (aluOp)
			ALU_ADD: result = rs1Data + opB;
			ALU_SUB: result = rs1Data - opB;
			ALU_SLL: result = rs1Data << shamt;
			ALU_SLT: result = {{(`XLEN-1){1'b0}}, lessSigned};
			ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lessUnsigned};
			ALU_XOR: result = rs1Data ^ opB;
			ALU_SRL: result = rs1Data >> shamt;
			ALU_SRA: result = $unsigned($signed(rs1Data) >>> shamt);
			ALU_OR: result = rs1Data | opB;
			default: result = rs1Data & opB;
		endcase
	end

	assign zero = (result == '0); // beq compares via sub

endmodule

`default_nettype wire

// ==== hdl/writeBack.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module writeBack import ctrlPkg::*; (
	input wire [`XLEN-1:0] aluResult,
	input wire [`XLEN-1:0] readData,
	input wire memSize_t memSize,
	input wire loadSigned,
	input wire [`XLEN-1:0] pcPlus4,
	input wire [`XLEN-1:0] pcImm,
	input wire wbSel_t wbSel,
	output logic [`XLEN-1:0] writeData
);
	logic [`XLEN-1:0] loadValue;

	// loaded bytes arrive in the low bits
	always_comb begin
		case (memSize)
			BYTE: loadValue = {{(`XLEN-8){loadSigned & readData[7]}}, readData[7:0]};
			HALF: loadValue = {{(`XLEN-16){loadSigned & readData[15]}}, readData[15:0]};
			default: loadValue = readData;
		endcase
	end

	always_comb begin
		case (wbSel)
			WB_MEM: writeData = loadValue;
			WB_PC4: writeData = pcPlus4; // jal, jalr link
			WB_PCIMM: writeData = pcImm; // auipc
			default: writeData = aluResult;
		endcase
	end

	// decoder maps funct3 11 and every invalid word to WORD
	always_comb begin
		sizeLegal: assert (memSize != memSize_t'(2'd3));
	end

endmodule

`default_nettype wire

// ==== hdl/coreTop.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module coreTop import ctrlPkg::*; (
	input wire clk,
	input wire arstN,
	input wire [31:0] inst,
	input wire [`XLEN-1:0] readData,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] aluResult,
	output logic [`XLEN-1:0] storeData,
	output memSize_t dataLen,
	output logic memWrite,
	output logic invalid
);
	logic [`XLEN-1:0] imm;
	aluOp_t aluOp;
	logic aluSrc;
	logic regWrite;
	wbSel_t wbSel;
	logic loadSigned;
	logic branch;
	jump_t jump;
	logic useZeroRs1;
	logic zero;
	logic [`XLEN-1:0] pcPlus4, pcImm;
	logic [`XLEN-1:0] rs1Data, rs2Data, writeData;
	logic [$clog2(`REG_COUNT)-1:0] rs1Addr;

	assign rs1Addr = useZeroRs1 ? '0 : inst[19:15]; // lui adds to x0
	assign storeData = rs2Data;

	fetchUnit fetch (
		.clk(clk), .arstN(arstN),
		.imm(imm), .aluResult(aluResult), .zero(zero),
		.branch(branch), .jump(jump),
		.pc(pc), .pcPlus4(pcPlus4), .pcImm(pcImm)
	);

	decoder dec (
		.inst(inst), .imm(imm), .aluOp(aluOp), .aluSrc(aluSrc),
		.regWrite(regWrite), .memWrite(memWrite), .wbSel(wbSel),
		.memSize(dataLen), .loadSigned(loadSigned), .branch(branch),
		.jump(jump), .useZeroRs1(useZeroRs1), .invalid(invalid)
	);

	regFile regs (
		.clk(clk), .arstN(arstN),
		.rs1Addr(rs1Addr), .rs2Addr(inst[24:20]), .rdAddr(inst[11:7]),
		.writeData(writeData), .regWrite(regWrite),
		.rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	alu alu0 (
		.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
		.aluSrc(aluSrc), .aluOp(aluOp),
		.result(aluResult), .zero(zero)
	);

	writeBack wb (
		.aluResult(aluResult), .readData(readData),
		.memSize(dataLen), .loadSigned(loadSigned),
		.pcPlus4(pcPlus4), .pcImm(pcImm), .wbSel(wbSel),
		.writeData(writeData)
	);

endmodule

`default_nettype wire

// ==== tb/coreTb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module coreTb import isaPkg::*, ctrlPkg::*; ();
	localparam int NUM_CYCLES = 3000;
	localparam int RESET_CYCLES = 16;

	logic clk;
	logic arstN;
	logic [31:0] inst;
	logic [`XLEN-1:0] readData;
	logic [`XLEN-1:0] pc, aluResult, storeData;
	memSize_t dataLen;
	logic memWrite, invalid;

	logic [31:0] lfsr = 32'd85;
	logic [`XLEN-1:0] modelRegs [`REG_COUNT];
	logic [`XLEN-1:0] modelPc;

	coreTop uut (
		.clk(clk), .arstN(arstN), .inst(inst), .readData(readData),
		.pc(pc), .aluResult(aluResult), .storeData(storeData),
		.dataLen(dataLen), .memWrite(memWrite), .invalid(invalid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
			input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic [31:0] loadExtend(input logic [2:0] f3, input logic [31:0] d);
		case (f3)
			F3_LB: return {{24{d[7]}}, d[7:0]};
			F3_LH: return {{16{d[15]}}, d[15:0]};
			F3_LBU: return {24'b0, d[7:0]};
			F3_LHU: return {16'b0, d[15:0]};
			default: return d;
		endcase
	endfunction

	function automatic logic [31:0] genInstruction();
		logic [31:0] kind, rd, rs1, rs2, f3, val, hi, s, coin, off, word;
		kind = randBits(4);
		rd = randBits(5);
		rs1 = randBits(5);
		rs2 = randBits(5);
		f3 = randBits(3);
		val = randBits(12);
		hi = randBits(20);
		s = randBits(8);
		coin = randBits(1);
		off = {{23{s[7]}}, s[7:0], 1'b0}; // small and even
		if (kind[3:0] == 4'd6 && coin[0])
			rs2 = rs1; // equal sources, beq taken
		case (kind[3:0])
			4'd0: word = randBits(32);
			4'd1: word = INST_EBREAK;
			4'd2: word = {hi[19:0], rd[4:0], OPC_LUI};
			4'd3: word = {hi[19:0], rd[4:0], OPC_AUIPC};
			4'd4: word = {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
			4'd5: word = {val[11:0], rs1[4:0], F3_JALR, rd[4:0], OPC_JALR};
			4'd6: word = {off[12], off[10:5], rs2[4:0], rs1[4:0], F3_BEQ,
				off[4:1], off[11], OPC_BRANCH};
			4'd7, 4'd8: word = {val[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_LOAD};
			4'd9, 4'd10: word = {val[11:5], rs2[4:0], rs1[4:0], 1'b0, f3[1:0], val[4:0],
				OPC_STORE};
			4'd11, 4'd12: word = {val[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OPIMM};
			4'd13, 4'd14: word = {1'b0, coin[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0],
				OPC_OP};
			default: word = {hi[19:0], rd[4:0], OPC_SYSTEM}; // almost never ebreak
		endcase
		return word;
	endfunction

	task automatic reportMismatch(input string msg);
		$display("Mismatch at %0d ns: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic checkWord(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
			input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic checkSize(input memSize_t got, input memSize_t exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// drives one word at +1 ns, checks at +3 ns, then steps the model
	task automatic runInstruction(input logic [31:0] word, input logic [`XLEN-1:0] data);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] rd;
		logic [`XLEN-1:0] a, b, iImm, sImm, bImm, uImm, jImm;
		logic [`XLEN-1:0] wval, nextPc, expAlu;
		logic ok, wr, chkAlu, isMem, expStore;
		memSize_t expLen;
		f3 = word[14:12];
		f7 = word[31:25];
		rd = word[11:7];
		a = modelRegs[word[19:15]];
		b = modelRegs[word[24:20]];
		iImm = {{20{word[31]}}, word[31:20]};
		sImm = {{20{word[31]}}, word[31:25], word[11:7]};
		bImm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
		uImm = {word[31:12], 12'b0};
		jImm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
		ok = 1'b0;
		wr = 1'b0;
		chkAlu = 1'b1;
		isMem = 1'b0;
		expStore = 1'b0;
		wval = '0;
		expAlu = '0;
		nextPc = modelPc + 32'd4;
		case (f3)
			F3_LB, F3_LBU: expLen = BYTE;
			F3_LH, F3_LHU: expLen = HALF;
			default: expLen = WORD;
		endcase
		case (word[6:0])
			OPC_LUI: begin
				ok = 1'b1;
				wr = 1'b1;
				wval = uImm;
				expAlu = uImm;
			end
			OPC_AUIPC: begin
				ok = 1'b1;
				wr = 1'b1;
				wval = modelPc + uImm;
				chkAlu = 1'b0;
			end
			OPC_JAL: begin
				ok = 1'b1;
				wr = 1'b1;
				wval = modelPc + 32'd4;
				nextPc = modelPc + jImm;
				chkAlu = 1'b0;
			end
			OPC_JALR: begin
				ok = (f3 == F3_JALR);
				wr = 1'b1;
				wval = modelPc + 32'd4;
				expAlu = a + iImm;
				nextPc = expAlu & ~32'd1;
			end
			OPC_BRANCH: begin
				ok = (f3 == F3_BEQ);
				chkAlu = 1'b0;
				if (a == b)
					nextPc = modelPc + bImm;
			end
			OPC_LOAD: begin
				ok = f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
				wr = 1'b1;
				isMem = 1'b1;
				expAlu = a + iImm; // address
				wval = loadExtend(f3, data);
			end
			OPC_STORE: begin
				ok = f3 inside {F3_LB, F3_LH, F3_LW};
				isMem = 1'b1;
				expStore = 1'b1;
				expAlu = a + sImm;
			end
			OPC_OPIMM: begin
				ok = (f3 != F3_SLL) && (f3 != F3_SR);
				wr = 1'b1;
				wval = aluModel(f3, 1'b0, a, iImm);
				expAlu = wval;
			end
			OPC_OP: begin
				ok = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR));
				wr = 1'b1;
				wval = aluModel(f3, f7[5], a, b);
				expAlu = wval;
			end
			OPC_SYSTEM: begin
				ok = (word == INST_EBREAK);
				chkAlu = 1'b0;
			end
			default: chkAlu = 1'b0;
		endcase
		if (!ok) begin
			wr = 1'b0; // plain pc + 4, nothing written
			chkAlu = 1'b0;
			isMem = 1'b0;
			expStore = 1'b0;
			nextPc = modelPc + 32'd4;
		end
		inst = word;
		readData = data;
		#2;
		checkWord(pc, modelPc, $sformatf("pc at %h", word));
		checkBit(invalid, !ok, $sformatf("invalid for %h", word));
		checkBit(memWrite, expStore, $sformatf("memWrite for %h", word));
		checkWord(storeData, b, $sformatf("storeData for %h", word));
		if (chkAlu)
			checkWord(aluResult, expAlu, $sformatf("aluResult for %h", word));
		if (isMem)
			checkSize(dataLen, expLen, $sformatf("dataLen for %h", word));
		if (wr && rd != 5'd0)
			modelRegs[rd] = wval;
		modelPc = nextPc;
		@(posedge clk);
		#1;
	endtask

	initial begin
		logic [31:0] word;
		arstN = 1'b0;
		inst = '0; // invalid word, no strobes
		readData = '0;
		modelPc = `RESET_PC;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#1;
			checkWord(pc, `RESET_PC, "pc during reset");
		end
		arstN = 1'b1;
		// or x0, xi, xi reads back every register
		for (int i = 0; i < `REG_COUNT; i++)
			runInstruction({7'b0, i[4:0], i[4:0], F3_OR, 5'd0, OPC_OP}, '0);
		repeat (NUM_CYCLES) begin
			word = genInstruction();
			runInstruction(word, randBits(32));
		end
		$display("TB PASSED");
		$finish;
	end

	initial begin
		#((RESET_CYCLES + `REG_COUNT + NUM_CYCLES) * 4 + 100);
		$display("watchdog expired before the test sequence finished");
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/fetchUnit.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/writeBack.sv
hdl/coreTop.sv
tb/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
	-f tb.f --top-module coreTb -o coreTb
./obj_dir/coreTb
